// File: Makefile
# Verilator build and run of the memory subsystem testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module memSystem_tb \
		-f memSystem.f -o memSystemSim
	./obj_dir/memSystemSim | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/memSystem_checker.sv
// Credit and reset assertions, bound into the transfer engine and the result port
// Signals that a bound module does not have are tied to harmless constants
`timescale 1ns/1ps
`default_nettype none

module memSystem_checker (
	input logic clk,
	input logic rst,
	input memPkg::engineStateE state,
	input logic dumpIssue,
	input logic resultCanIssue,
	input logic resultValid,
	input logic [memPkg::CREDIT_CNT_WIDTH-1:0] creditCount,
	input logic sramWe,
	input logic rfWe
);

	// A result always follows an issue two cycles earlier
	assert property (@(posedge clk) disable iff (rst) resultValid |-> $past(dumpIssue, 2))
		else $error("resultValid rose without a DUMP read issued two cycles before");

	// Saturating counter never passes its limit
	assert property (@(posedge clk) disable iff (rst)
		creditCount <= memPkg::CREDIT_CNT_WIDTH'(memPkg::RESULT_CREDIT_MAX))
		else $error("result credit count above its maximum");

	// DUMP reads only against a held credit and only while dumping
	assert property (@(posedge clk) disable iff (rst)
		dumpIssue |-> resultCanIssue && (state == memPkg::ST_DUMP))
		else $error("DUMP read issued without a result credit");

	// Outputs quiet in the first cycle after reset
	assert property (@(posedge clk) $past(rst) && !rst |-> !resultValid && !sramWe && !rfWe)
		else $error("resultValid or a write enable high right after reset");

endmodule

// Result port has no engine state, and only dumps ever issue
bind resultPort memSystem_checker i_checker (
	.clk(clk), .rst(rst), .state(memPkg::ST_DUMP), .dumpIssue(dumpIssue),
	.resultCanIssue(resultCanIssue), .resultValid(resultValid), .creditCount(creditCount),
	.sramWe(1'b0), .rfWe(1'b0)
);

bind transferEngine memSystem_checker i_checker (
	.clk(clk), .rst(rst), .state(state), .dumpIssue(dumpIssue),
	.resultCanIssue(resultCanIssue), .resultValid(1'b0), .creditCount('0),
	.sramWe(sramWe), .rfWe(rfWe)
);

`default_nettype wire

// File: dv/memSystem_tb.sv
// Table-driven testbench for the block-transfer memory subsystem
// Reference SRAM and register file follow each command in issue order
// The sink keeps fewer than RESULT_CREDIT_MAX grants unanswered, so no grant is dropped
`timescale 1ns/1ps
`default_nettype none

module memSystem_tb;

	// One stimulus row
	typedef struct packed {
		memPkg::opcodeE opcode;
		logic [memPkg::BLOCK_SEL_WIDTH-1:0] block;
		logic randSeed;
		logic [memPkg::DATA_WIDTH-1:0] seed;
		logic slowGrant;
	} rowT;

	// Expected result, tagged with how the sink grants credit for it
	typedef struct packed {
		logic slowGrant;
		memPkg::resultT res;
	} expectT;

	logic clk = 1'b0;
	logic rst;
	logic cmdValid;
	memPkg::memCmdT cmd;
	logic cmdCreditReturn;
	logic resultCredit;
	logic resultValid;
	memPkg::resultT result;

	// opcode, block, seed from LFSR, fixed seed, random credit gaps
	rowT stimTable [13] = '{
		'{memPkg::OP_FILL, 6'd3, 1'b0, 32'h0000_0010, 1'b0},
		'{memPkg::OP_LOAD, 6'd3, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_DUMP, 6'd3, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_WRITEBACK, 6'd9, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_FILL, 6'd3, 1'b1, 32'h0, 1'b0},
		'{memPkg::OP_LOAD, 6'd9, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_DUMP, 6'd9, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_FILL, 6'd40, 1'b1, 32'h0, 1'b0},
		'{memPkg::OP_LOAD, 6'd40, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_DUMP, 6'd40, 1'b0, 32'h0, 1'b1},
		'{memPkg::OP_WRITEBACK, 6'd63, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_LOAD, 6'd63, 1'b0, 32'h0, 1'b0},
		'{memPkg::OP_DUMP, 6'd63, 1'b0, 32'h0, 1'b1}
	};

	logic [memPkg::DATA_WIDTH-1:0] refSram [memPkg::SRAM_WORDS];
	logic [memPkg::DATA_WIDTH-1:0] refRf [memPkg::BLOCK_WORDS];
	expectT expQ [$];
	logic [31:0] lfsr = 32'h5337428c;
	logic sinkActive = 1'b0;
	int hostCredits = memPkg::CMD_CREDITS;
	int commandsSent = 0;
	int creditReturns = 0;
	int dumpWords = 0;
	int resultsSeen = 0;
	int grantsGiven = 0;
	int checks = 0;
	int errors = 0;

	memSystem i_memSystem (
		.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmd(cmd), .cmdCreditReturn(cmdCreditReturn),
		.resultCredit(resultCredit), .resultValid(resultValid), .result(result)
	);

	always #5 clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Apply one command to the reference memories, queue DUMP results
	task automatic updateReference(input memPkg::memCmdT c, input logic slow);
		int base;
		expectT e;
		base = c.block * memPkg::BLOCK_WORDS;
		for (int i = 0; i < memPkg::BLOCK_WORDS; i++) begin
			case (c.opcode)
				memPkg::OP_FILL: refSram[base + i] = c.seed - i;
				memPkg::OP_LOAD: refRf[i] = refSram[base + i];
				memPkg::OP_WRITEBACK: refSram[base + i] = refRf[i];
				default: begin
					e.slowGrant = slow;
					e.res.index = memPkg::INDEX_WIDTH'(i);
					e.res.data = refRf[i];
					expQ.push_back(e);
					dumpWords++;
				end
			endcase
		end
	endtask

	// Sample outputs at the falling edge, then drive the next inputs
	task automatic stepCycle;
		expectT e;
		logic slow;
		@(negedge clk);
		if (cmdCreditReturn) begin
			hostCredits++;
			creditReturns++;
		end
		if (resultValid) begin
			resultsSeen++;
			if (expQ.size() == 0) begin
				errors++;
				$display("Result index %0d arrived with no DUMP outstanding", result.index);
			end else begin
				e = expQ.pop_front();
				checkValue($sformatf("DUMP word %0d index", e.res.index), e.res.index, result.index);
				checkValue($sformatf("DUMP word %0d data", e.res.index), e.res.data, result.data);
			end
		end
		checkValue("results within granted credits", 1'b1, resultsSeen <= grantsGiven);
		// Grant style follows the oldest outstanding result
		resultCredit = 1'b0;
		if (sinkActive && (grantsGiven - resultsSeen < memPkg::RESULT_CREDIT_MAX)) begin
			slow = (expQ.size() != 0) && expQ[0].slowGrant;
			if (!slow || randomBits(2) == 0) begin
				resultCredit = 1'b1;
				grantsGiven++;
			end
		end
		cmdValid = 1'b0;
	endtask

	// Send one table row as soon as a command credit is held
	task automatic sendCommand(input int r);
		memPkg::memCmdT c;
		while (hostCredits == 0) begin
			stepCycle();
		end
		c.opcode = stimTable[r].opcode;
		c.block = stimTable[r].block;
		c.seed = stimTable[r].randSeed ? randomBits(32) : stimTable[r].seed;
		updateReference(c, stimTable[r].slowGrant);
		cmd = c;
		cmdValid = 1'b1;
		hostCredits--;
		commandsSent++;
		stepCycle();
	endtask

	initial begin
		rst = 1'b1;
		cmdValid = 1'b0;
		cmd = '0;
		resultCredit = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		// Quiet outputs with no command, first without grants then with some
		for (int i = 0; i < 8; i++) begin
			sinkActive = (i >= 4);
			stepCycle();
			checkValue("idle cmdCreditReturn", 1'b0, cmdCreditReturn);
			checkValue("idle resultValid", 1'b0, resultValid);
		end
		for (int r = 0; r < $size(stimTable); r++) begin
			sendCommand(r);
		end
		// Drain results and wait until the host holds its full credit again
		while (expQ.size() != 0 || hostCredits < memPkg::CMD_CREDITS) begin
			stepCycle();
		end
		repeat (8) stepCycle();
		checkValue("credit returns per command", commandsSent, creditReturns);
		checkValue("results per DUMP word", dumpWords, resultsSeen);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog, 40 cycles per row plus reset, 40 more per withheld credit
	initial begin
		int slowDumps;
		int limit;
		slowDumps = 0;
		for (int r = 0; r < $size(stimTable); r++) begin
			if (stimTable[r].opcode == memPkg::OP_DUMP && stimTable[r].slowGrant) begin
				slowDumps++;
			end
		end
		limit = ($size(stimTable) + 1) * 40 + slowDumps * memPkg::BLOCK_WORDS * 40;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: memSystem.f
source/memPkg.sv
source/cmdDecoder.sv
source/transferEngine.sv
source/sramArray.sv
source/regFile.sv
source/resultPort.sv
source/memSystem.sv
dv/memSystem_checker.sv
dv/memSystem_tb.sv

// File: source/cmdDecoder.sv
// Two-entry command FIFO in front of the transfer engine
// The host may only send while it holds a credit, so a full buffer is never written
// Credits return one cycle after the engine takes an entry
`timescale 1ns/1ps
`default_nettype none

module cmdDecoder (
	input logic clk,
	input logic rst,
	input logic cmdValid,
	input memPkg::memCmdT cmd,
	input logic decTake,
	output logic decValid,
	output memPkg::memCmdT decCmd,
	output logic cmdCreditReturn
);

	// Buffer storage holds payload only
	memPkg::memCmdT buffer [memPkg::CMD_CREDITS];

	// Pointers carry one extra wrap bit to tell full from empty
	logic [memPkg::CMD_PTR_WIDTH:0] wrPtr;
	logic [memPkg::CMD_PTR_WIDTH:0] rdPtr;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (wrPtr == rdPtr);
	// Same slot but different lap means every entry is occupied
	assign full = (wrPtr[memPkg::CMD_PTR_WIDTH] != rdPtr[memPkg::CMD_PTR_WIDTH]) &&
		(wrPtr[memPkg::CMD_PTR_WIDTH-1:0] == rdPtr[memPkg::CMD_PTR_WIDTH-1:0]);

	assign push = cmdValid && !full;
	assign pop = decTake && !empty;

	// Head of the buffer goes straight to the engine
	assign decValid = !empty;
	assign decCmd = buffer[rdPtr[memPkg::CMD_PTR_WIDTH-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			cmdCreditReturn <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			// One credit back per entry removed
			cmdCreditReturn <= pop;
		end
	end

	// Capture the arriving command, visible at the head next cycle
	always_ff @(posedge clk) begin
		if (push) begin
			buffer[wrPtr[memPkg::CMD_PTR_WIDTH-1:0]] <= cmd;
		end
	end

endmodule

`default_nettype wire

// File: source/memPkg.sv
// Shared widths, encodings and bus structs for the block-transfer memory subsystem
// Block select plus word index must fill the SRAM address exactly
// Buffer depth and credit limits here also bound the host and sink behaviour
`default_nettype none

package memPkg;

	// Memory geometry
	localparam int SRAM_WORDS = 2048;
	localparam int BLOCK_WORDS = 32;
	localparam int DATA_WIDTH = 32;

	// Derived address widths
	localparam int SRAM_ADDR_WIDTH = $clog2(SRAM_WORDS);
	localparam int INDEX_WIDTH = $clog2(BLOCK_WORDS);
	localparam int BLOCK_SEL_WIDTH = SRAM_ADDR_WIDTH - INDEX_WIDTH;

	// Command buffer depth equals the host's starting credit
	localparam int CMD_CREDITS = 2;
	localparam int CMD_PTR_WIDTH = $clog2(CMD_CREDITS);

	// Result credits held by the result port
	localparam int RESULT_CREDIT_MAX = 4;
	localparam int CREDIT_CNT_WIDTH = $clog2(RESULT_CREDIT_MAX + 1);

	// All four codes are legal operations
	typedef enum logic [1:0] {
		OP_FILL = 2'd0,
		OP_LOAD = 2'd1,
		OP_DUMP = 2'd2,
		OP_WRITEBACK = 2'd3
	} opcodeE;

	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_FILL = 3'd1,
		ST_LOAD = 3'd2,
		ST_DUMP = 3'd3,
		ST_WRITEBACK = 3'd4
	} engineStateE;

	// One host command, 40 bits
	typedef struct packed {
		opcodeE opcode;
		logic [BLOCK_SEL_WIDTH-1:0] block;
		logic [DATA_WIDTH-1:0] seed;
	} memCmdT;

	// One DUMP result, 37 bits
	typedef struct packed {
		logic [INDEX_WIDTH-1:0] index;
		logic [DATA_WIDTH-1:0] data;
	} resultT;

endpackage

`default_nettype wire

// File: source/memSystem.sv
// Top level of the block-transfer memory subsystem
// Host must respect command credits and the sink grants result credits
// Everything runs on clk with a synchronous active-high reset
`timescale 1ns/1ps
`default_nettype none

module memSystem (
	input logic clk,
	input logic rst,
	input logic cmdValid,
	input memPkg::memCmdT cmd,
	output logic cmdCreditReturn,
	input logic resultCredit,
	output logic resultValid,
	output memPkg::resultT result
);

	// Decoder to engine
	logic decValid;
	memPkg::memCmdT decCmd;
	logic decTake;

	// Engine to memories
	logic sramWe;
	logic [memPkg::SRAM_ADDR_WIDTH-1:0] sramAddr;
	logic [memPkg::DATA_WIDTH-1:0] sramWdata;
	logic [memPkg::DATA_WIDTH-1:0] sramRdata;
	logic rfWe;
	logic [memPkg::INDEX_WIDTH-1:0] rfWaddr;
	logic [memPkg::DATA_WIDTH-1:0] rfWdata;
	logic [memPkg::INDEX_WIDTH-1:0] rfRaddr;
	logic [memPkg::DATA_WIDTH-1:0] rfRdata;

	// Engine to result port
	logic resultCanIssue;
	logic dumpIssue;
	logic [memPkg::INDEX_WIDTH-1:0] dumpIndex;

	cmdDecoder i_cmdDecoder (
		.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmd(cmd), .decTake(decTake),
		.decValid(decValid), .decCmd(decCmd), .cmdCreditReturn(cmdCreditReturn)
	);

	transferEngine i_transferEngine (
		.clk(clk), .rst(rst), .decValid(decValid), .decCmd(decCmd), .decTake(decTake),
		.sramWe(sramWe), .sramAddr(sramAddr), .sramWdata(sramWdata), .sramRdata(sramRdata),
		.rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata), .rfRdata(rfRdata),
		.rfRaddr(rfRaddr), .resultCanIssue(resultCanIssue), .dumpIssue(dumpIssue),
		.dumpIndex(dumpIndex)
	);

	sramArray i_sramArray (
		.clk(clk), .we(sramWe), .addr(sramAddr), .wdata(sramWdata), .rdata(sramRdata)
	);

	regFile i_regFile (
		.clk(clk), .we(rfWe), .waddr(rfWaddr), .wdata(rfWdata), .raddr(rfRaddr),
		.rdata(rfRdata)
	);

	resultPort i_resultPort (
		.clk(clk), .rst(rst), .dumpIssue(dumpIssue), .dumpIndex(dumpIndex),
		.rfRdata(rfRdata), .resultCredit(resultCredit), .resultCanIssue(resultCanIssue),
		.resultValid(resultValid), .result(result)
	);

endmodule

`default_nettype wire

// File: source/regFile.sv
// Register file of 32 words with one write port and one registered read port
// Read of the address under write returns the old value
// No reset, registers hold garbage until loaded
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic we,
	input logic [memPkg::INDEX_WIDTH-1:0] waddr,
	input logic [memPkg::DATA_WIDTH-1:0] wdata,
	input logic [memPkg::INDEX_WIDTH-1:0] raddr,
	output logic [memPkg::DATA_WIDTH-1:0] rdata
);

	logic [memPkg::DATA_WIDTH-1:0] regs [memPkg::BLOCK_WORDS];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Read port, one cycle of latency
	always_ff @(posedge clk) begin
		rdata <= regs[raddr];
	end

endmodule

`default_nettype wire

// File: source/resultPort.sv
// Result output for DUMP with sink credit tracking
// Credits start at zero and saturate at RESULT_CREDIT_MAX
// Each result leaves two cycles after its issue, one per register file read
`timescale 1ns/1ps
`default_nettype none

module resultPort (
	input logic clk,
	input logic rst,
	input logic dumpIssue,
	input logic [memPkg::INDEX_WIDTH-1:0] dumpIndex,
	input logic [memPkg::DATA_WIDTH-1:0] rfRdata,
	input logic resultCredit,
	output logic resultCanIssue,
	output logic resultValid,
	output memPkg::resultT result
);

	logic [memPkg::CREDIT_CNT_WIDTH-1:0] creditCount;
	// Issue and index lined up with the register file data
	logic issueDly;
	logic [memPkg::INDEX_WIDTH-1:0] indexDly;

	// Engine may read only against a held credit
	assign resultCanIssue = (creditCount != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			creditCount <= '0;
			issueDly <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			issueDly <= dumpIssue;
			resultValid <= issueDly;
			// Issue and grant together cancel
			if (resultCredit && !dumpIssue) begin
				// Grants beyond the maximum are dropped
				if (creditCount != memPkg::CREDIT_CNT_WIDTH'(memPkg::RESULT_CREDIT_MAX)) begin
					creditCount <= creditCount + 1'b1;
				end
			end else if (dumpIssue && !resultCredit) begin
				creditCount <= creditCount - 1'b1;
			end
		end
	end

	// Payload path
	always_ff @(posedge clk) begin
		indexDly <= dumpIndex;
		result.index <= indexDly;
		result.data <= rfRdata;
	end

endmodule

`default_nettype wire

// File: source/sramArray.sv
// Single-port synchronous SRAM, 2048 words of 32 bits
// Read data appears one cycle after the address
// A read of the word being written returns the old contents
// Contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module sramArray (
	input logic clk,
	input logic we,
	input logic [memPkg::SRAM_ADDR_WIDTH-1:0] addr,
	input logic [memPkg::DATA_WIDTH-1:0] wdata,
	output logic [memPkg::DATA_WIDTH-1:0] rdata
);

	logic [memPkg::DATA_WIDTH-1:0] mem [memPkg::SRAM_WORDS];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read, every cycle
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: source/transferEngine.sv
// Sequences FILL, LOAD, DUMP and WRITEBACK over one 32-word block at a time
// Both memories have one cycle of read latency, so copies keep one word in flight
// DUMP reads stall whenever the result port has no credit
// Commands run one at a time, taken only from ST_IDLE
`timescale 1ns/1ps
`default_nettype none

module transferEngine (
	input logic clk,
	input logic rst,
	input logic decValid,
	input memPkg::memCmdT decCmd,
	output logic decTake,
	output logic sramWe,
	output logic [memPkg::SRAM_ADDR_WIDTH-1:0] sramAddr,
	output logic [memPkg::DATA_WIDTH-1:0] sramWdata,
	input logic [memPkg::DATA_WIDTH-1:0] sramRdata,
	output logic rfWe,
	output logic [memPkg::INDEX_WIDTH-1:0] rfWaddr,
	output logic [memPkg::DATA_WIDTH-1:0] rfWdata,
	input logic [memPkg::DATA_WIDTH-1:0] rfRdata,
	output logic [memPkg::INDEX_WIDTH-1:0] rfRaddr,
	input logic resultCanIssue,
	output logic dumpIssue,
	output logic [memPkg::INDEX_WIDTH-1:0] dumpIndex
);

	memPkg::engineStateE state;
	memPkg::memCmdT cmdReg;

	// Word index and its copy one cycle behind, for data returning from a read
	logic [memPkg::INDEX_WIDTH-1:0] index;
	logic [memPkg::INDEX_WIDTH-1:0] indexDly;
	// Descending FILL value
	logic [memPkg::DATA_WIDTH-1:0] pattern;

	// Reads still to be issued for the current command
	logic issuing;
	// A read was issued last cycle and its data is on the read port now
	logic readPending;
	logic readIssue;
	logic fillStep;
	logic advance;
	logic lastWord;

	// Take the next command as soon as the engine is free
	assign decTake = (state == memPkg::ST_IDLE) && decValid;

	assign fillStep = (state == memPkg::ST_FILL);
	// Copies read every cycle, DUMP reads only against a credit
	assign readIssue = issuing && ((state == memPkg::ST_LOAD) ||
		(state == memPkg::ST_WRITEBACK) ||
		((state == memPkg::ST_DUMP) && resultCanIssue));
	assign advance = fillStep || readIssue;
	assign lastWord = (index == memPkg::INDEX_WIDTH'(memPkg::BLOCK_WORDS - 1));

	// SRAM side
	// WRITEBACK writes the word read from the register file last cycle
	assign sramWe = fillStep || ((state == memPkg::ST_WRITEBACK) && readPending);
	assign sramAddr = {cmdReg.block, (state == memPkg::ST_WRITEBACK) ? indexDly : index};
	assign sramWdata = fillStep ? pattern : rfRdata;

	// Register file side
	// LOAD writes the word read from the SRAM last cycle
	assign rfWe = (state == memPkg::ST_LOAD) && readPending;
	assign rfWaddr = indexDly;
	assign rfWdata = sramRdata;
	assign rfRaddr = index;

	// DUMP read request towards the result port
	assign dumpIssue = readIssue && (state == memPkg::ST_DUMP);
	assign dumpIndex = index;

	// Control state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= memPkg::ST_IDLE;
			issuing <= 1'b0;
			readPending <= 1'b0;
		end else begin
			readPending <= readIssue;
			if (advance && lastWord) begin
				issuing <= 1'b0;
			end
			unique case (state)
				memPkg::ST_IDLE: begin
					if (decTake) begin
						issuing <= 1'b1;
						unique case (decCmd.opcode)
							memPkg::OP_FILL: state <= memPkg::ST_FILL;
							memPkg::OP_LOAD: state <= memPkg::ST_LOAD;
							memPkg::OP_DUMP: state <= memPkg::ST_DUMP;
							memPkg::OP_WRITEBACK: state <= memPkg::ST_WRITEBACK;
						endcase
					end
				end
				// 32 write cycles, no read involved
				memPkg::ST_FILL: begin
					if (lastWord) begin
						state <= memPkg::ST_IDLE;
					end
				end
				// Leave once the final read's data has been handled
				memPkg::ST_LOAD,
				memPkg::ST_WRITEBACK,
				memPkg::ST_DUMP: begin
					if (!issuing) begin
						state <= memPkg::ST_IDLE;
					end
				end
				default: begin
					state <= memPkg::ST_IDLE;
				end
			endcase
		end
	end

	// Index, pattern and the latched command
	always_ff @(posedge clk) begin
		indexDly <= index;
		if (decTake) begin
			cmdReg <= decCmd;
			index <= '0;
			pattern <= decCmd.seed;
		end else begin
			if (advance) begin
				index <= index + 1'b1;
			end
			// Word i gets seed minus i
			if (fillStep) begin
				pattern <= pattern - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
